//--- logic/uart_pkg.sv
package uart_pkg;

  localparam int NcoWidth       = 16;
  localparam int OversampleRate = 16;

  typedef logic [7:0]          byte_t;
  typedef logic [NcoWidth-1:0] nco_t;

  // frame settings held by the host
  typedef struct packed {
    logic tx_en;
    logic rx_en;
    logic parity_en;
    logic parity_odd;
    nco_t nco;
  } uart_cfg_t;

  // one-cycle receive error pulses
  typedef struct packed {
    logic frame;
    logic parity;
    logic overflow;
  } rx_err_t;

endpackage

//--- logic/uart_baud_gen.sv
`timescale 1ns/1ps

module uart_baud_gen import uart_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic en_i,
  input  nco_t nco_i,
  output logic tick_o
);

  // top bit catches the carry of each add
  logic [NcoWidth:0] acc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= {1'b0, acc_q[NcoWidth-1:0]} + {1'b0, nco_i};
    end
  end

  // tick rate is fclk * nco / 2**NcoWidth
  assign tick_o = acc_q[NcoWidth] & en_i;

endmodule

//--- logic/uart_req_ack_port.sv
`timescale 1ns/1ps

module uart_req_ack_port (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic ready_i,
  output logic ack_o,
  output logic strobe_o
);

  logic ack_q;

  // new transfer only while no ack is pending
  assign strobe_o = req_i & ready_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (ack_q) begin
      // release once the host has dropped req
      ack_q <= req_i;
    end else begin
      ack_q <= strobe_o;
    end
  end

  assign ack_o = ack_q;

endmodule

//--- logic/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; #(
  parameter int unsigned Depth = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  byte_t wdata_i,
  input  logic  pop_i,
  output byte_t rdata_o,
  output logic  full_o,
  output logic  empty_o
);

  localparam int unsigned PtrW = $clog2(Depth);
  localparam int unsigned CntW = $clog2(Depth + 1);

  byte_t           mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  byte_t           pop_q;
  logic            do_push;
  logic            do_pop;

  // wrap explicitly so depths other than powers of two work
  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // keeps the last popped byte stable after the pop
  always_ff @(posedge clk_i) begin
    if (do_pop) begin
      pop_q <= mem_q[rd_ptr_q];
    end
  end

  // head entry on the pop cycle, popped byte afterwards
  assign rdata_o = pop_i ? mem_q[rd_ptr_q] : pop_q;

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  uart_cfg_t cfg_i,
  input  logic      tick_i,
  input  logic      valid_i,
  input  byte_t     data_i,
  output logic      take_o,
  output logic      tx_o,
  output logic      idle_o
);

  localparam int TickW = $clog2(OversampleRate);

  typedef enum logic [2:0] {
    TxIdle,
    TxStart,
    TxData,
    TxParity,
    TxStop
  } tx_state_e;

  tx_state_e        state_q;
  logic [TickW-1:0] tick_cnt_q;
  logic [2:0]       bit_cnt_q;
  byte_t            shift_q;
  logic             parity_q;
  logic             tx_q;
  logic             bit_val;
  logic             bit_end;

  assign take_o  = (state_q == TxIdle) & cfg_i.tx_en & valid_i;
  assign bit_end = tick_i & (tick_cnt_q == TickW'(OversampleRate - 1));

  // level of the bit currently on the line
  always_comb begin
    unique case (state_q)
      TxStart:  bit_val = 1'b0;
      TxData:   bit_val = shift_q[0];
      TxParity: bit_val = parity_q;
      default:  bit_val = 1'b1;
    endcase
  end

  ////////////////////
  // frame sequencer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= TxIdle;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else begin
      // line changes on the first tick of each bit
      if (tick_i) begin
        tx_q <= bit_val;
      end
      if (state_q == TxIdle) begin
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
        if (take_o) begin
          state_q <= TxStart;
        end
      end else if (tick_i) begin
        tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
        if (bit_end) begin
          unique case (state_q)
            TxStart: state_q <= TxData;
            TxData: begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= cfg_i.parity_en ? TxParity : TxStop;
              end
            end
            TxParity: state_q <= TxStop;
            default:  state_q <= TxIdle;
          endcase
        end
      end
    end
  end

  // lsb first, parity fixed when the byte is taken
  always_ff @(posedge clk_i) begin
    if (take_o) begin
      shift_q  <= data_i;
      parity_q <= ^data_i ^ cfg_i.parity_odd;
    end else if (state_q == TxData && bit_end) begin
      shift_q <= {1'b1, shift_q[7:1]};
    end
  end

  assign tx_o   = tx_q;
  assign idle_o = (state_q == TxIdle);

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  uart_cfg_t cfg_i,
  input  logic      tick_i,
  input  logic      rx_i,
  output logic      byte_valid_o,
  output byte_t     byte_o,
  output rx_err_t   err_o
);

  localparam int TickW = $clog2(OversampleRate);

  typedef enum logic [2:0] {
    RxIdle,
    RxStart,
    RxData,
    RxParity,
    RxStop
  } rx_state_e;

  rx_state_e        state_q;
  logic [TickW-1:0] tick_cnt_q;
  logic [2:0]       bit_cnt_q;
  logic             sync_q1;
  logic             sync_q2;
  logic             line_q;
  byte_t            shift_q;
  logic             bad_par_q;
  logic             valid_q;
  logic             frame_err_q;
  logic             parity_err_q;
  logic             start_edge;
  logic             half_bit;
  logic             full_bit;

  ////////////////////
  // line input
  ////////////////////

  // two flop synchronizer plus one stage for the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
      line_q  <= 1'b1;
    end else begin
      sync_q1 <= rx_i;
      sync_q2 <= sync_q1;
      line_q  <= sync_q2;
    end
  end

  assign start_edge = line_q & ~sync_q2;
  assign half_bit   = tick_i & (tick_cnt_q == TickW'(OversampleRate / 2 - 1));
  assign full_bit   = tick_i & (tick_cnt_q == TickW'(OversampleRate - 1));

  ////////////////////
  // frame sequencer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= RxIdle;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      bad_par_q    <= 1'b0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (tick_i) begin
        tick_cnt_q <= full_bit ? '0 : tick_cnt_q + 1'b1;
      end
      unique case (state_q)
        RxIdle: begin
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
          bad_par_q  <= 1'b0;
          if (cfg_i.rx_en && start_edge) begin
            state_q <= RxStart;
          end
        end
        RxStart: begin
          // mid start bit, a high line was only a glitch
          if (half_bit) begin
            tick_cnt_q <= '0;
            state_q    <= sync_q2 ? RxIdle : RxData;
          end
        end
        RxData: begin
          if (full_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= cfg_i.parity_en ? RxParity : RxStop;
            end
          end
        end
        RxParity: begin
          if (full_bit) begin
            bad_par_q <= sync_q2 ^ (^shift_q) ^ cfg_i.parity_odd;
            state_q   <= RxStop;
          end
        end
        default: begin
          if (full_bit) begin
            valid_q      <= sync_q2 & ~bad_par_q;
            frame_err_q  <= ~sync_q2;
            parity_err_q <= bad_par_q;
            state_q      <= RxIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RxData && full_bit) begin
      shift_q <= {sync_q2, shift_q[7:1]};
    end
  end

  assign byte_valid_o = valid_q;
  assign byte_o       = shift_q;
  assign err_o        = '{frame: frame_err_q, parity: parity_err_q, overflow: 1'b0};

endmodule

//--- logic/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
  parameter int unsigned TxDepth = 4,
  parameter int unsigned RxDepth = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  uart_cfg_t cfg_i,
  input  logic      tx_req_i,
  input  byte_t     tx_data_i,
  output logic      tx_ack_o,
  input  logic      rd_req_i,
  output logic      rd_ack_o,
  output byte_t     rd_data_o,
  output logic      rx_avail_o,
  input  logic      rx_i,
  output logic      tx_o,
  output logic      tx_idle_o,
  output rx_err_t   rx_err_o
);

  logic    tick;
  logic    tx_push;
  logic    tx_take;
  logic    tx_full;
  logic    tx_empty;
  byte_t   tx_byte;
  logic    rd_pop;
  logic    rx_full;
  logic    rx_empty;
  logic    rx_byte_valid;
  byte_t   rx_byte;
  rx_err_t rx_err;

  uart_baud_gen i_baud_gen (
    .clk_i,
    .rst_ni,
    .en_i   (cfg_i.tx_en | cfg_i.rx_en),
    .nco_i  (cfg_i.nco),
    .tick_o (tick)
  );

  ////////////////////
  // transmit path
  ////////////////////

  uart_req_ack_port i_wr_port (
    .clk_i,
    .rst_ni,
    .req_i    (tx_req_i),
    .ready_i  (~tx_full),
    .ack_o    (tx_ack_o),
    .strobe_o (tx_push)
  );

  uart_fifo #(
    .Depth (TxDepth)
  ) i_tx_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (tx_push),
    .wdata_i (tx_data_i),
    .pop_i   (tx_take),
    .rdata_o (tx_byte),
    .full_o  (tx_full),
    .empty_o (tx_empty)
  );

  uart_tx i_tx (
    .clk_i,
    .rst_ni,
    .cfg_i,
    .tick_i  (tick),
    .valid_i (~tx_empty),
    .data_i  (tx_byte),
    .take_o  (tx_take),
    .tx_o,
    .idle_o  (tx_idle_o)
  );

  ////////////////////
  // receive path
  ////////////////////

  uart_rx i_rx (
    .clk_i,
    .rst_ni,
    .cfg_i,
    .tick_i       (tick),
    .rx_i,
    .byte_valid_o (rx_byte_valid),
    .byte_o       (rx_byte),
    .err_o        (rx_err)
  );

  uart_fifo #(
    .Depth (RxDepth)
  ) i_rx_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (rx_byte_valid),
    .wdata_i (rx_byte),
    .pop_i   (rd_pop),
    .rdata_o (rd_data_o),
    .full_o  (rx_full),
    .empty_o (rx_empty)
  );

  uart_req_ack_port i_rd_port (
    .clk_i,
    .rst_ni,
    .req_i    (rd_req_i),
    .ready_i  (~rx_empty),
    .ack_o    (rd_ack_o),
    .strobe_o (rd_pop)
  );

  assign rx_avail_o = ~rx_empty;

  // a byte arriving at a full FIFO is dropped there
  assign rx_err_o = '{
    frame:    rx_err.frame,
    parity:   rx_err.parity,
    overflow: rx_byte_valid & rx_full
  };

endmodule

//--- tests/uart_props.sv
`timescale 1ns/1ps

module uart_props import uart_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    tx_req_i,
  input logic    tx_ack_i,
  input logic    rd_req_i,
  input logic    rd_ack_i,
  input logic    tx_line_i,
  input logic    tx_idle_i,
  input logic    rx_avail_i,
  input rx_err_t rx_err_i
);

  // four-phase release, ack drops only once req has gone low
  tx_ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(tx_ack_i) |-> !$past(tx_req_i))
    else $error("tx_ack_o fell while tx_req_i was still high");

  rd_ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(rd_ack_i) |-> !$past(rd_req_i))
    else $error("rd_ack_o fell while rd_req_i was still high");

  // idle transmitter keeps the line at the stop level
  idle_line_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_idle_i |-> tx_line_i)
    else $error("tx_o low while tx_idle_o is high");

  // overflow needs a full FIFO, so the FIFO cannot just have become non-empty
  overflow_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_err_i.overflow |-> !$rose(rx_avail_i))
    else $error("overflow pulse on a rise of rx_avail_o");

endmodule

bind uart_top uart_props i_uart_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .tx_req_i   (tx_req_i),
  .tx_ack_i   (tx_ack_o),
  .rd_req_i   (rd_req_i),
  .rd_ack_i   (rd_ack_o),
  .tx_line_i  (tx_o),
  .tx_idle_i  (tx_idle_o),
  .rx_avail_i (rx_avail_o),
  .rx_err_i   (rx_err_o)
);

//--- tests/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

  localparam int unsigned TxDepth = 4;
  localparam int unsigned RxDepth = 4;
  localparam nco_t        NcoInc  = 16'h4000;
  // clocks per bit follow from the NCO rate and the oversampling
  localparam int          BitClks = OversampleRate * (65536 / NcoInc);
  localparam int          Timeout = 10000;

  typedef enum logic [1:0] {
    WatchTxAck,
    WatchRdAck,
    WatchRxAvail,
    WatchTxIdle
  } watch_e;

  logic      clk_i;
  logic      rst_ni;
  uart_cfg_t cfg;
  logic      tx_req;
  byte_t     tx_data;
  logic      tx_ack;
  logic      rd_req;
  logic      rd_ack;
  byte_t     rd_data;
  logic      rx_avail;
  logic      rx_line;
  logic      tx_line;
  logic      tx_idle;
  rx_err_t   rx_err;
  logic      inject_en;
  logic      inject_bit;

  byte_t     exp_q[$];
  byte_t     sent_q[$];
  int        err_cnt;
  int        check_cnt;
  int        frame_cnt;
  int        parity_cnt;
  int        ovf_cnt;
  logic      rd_ack_q;

  uart_top #(
    .TxDepth (TxDepth),
    .RxDepth (RxDepth)
  ) i_uart_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (cfg),
    .tx_req_i   (tx_req),
    .tx_data_i  (tx_data),
    .tx_ack_o   (tx_ack),
    .rd_req_i   (rd_req),
    .rd_ack_o   (rd_ack),
    .rd_data_o  (rd_data),
    .rx_avail_o (rx_avail),
    .rx_i       (rx_line),
    .tx_o       (tx_line),
    .tx_idle_o  (tx_idle),
    .rx_err_o   (rx_err)
  );

  // loopback unless a frame is being injected
  assign rx_line = inject_en ? inject_bit : tx_line;

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // reference model
  ////////////////////

  // line levels of one frame with bit 0 sent first
  function automatic logic [10:0] frame_bits(input byte_t data, input logic par_en,
                                             input logic par_odd);
    logic [10:0] bits;
    bits      = '1;
    bits[0]   = 1'b0;
    bits[8:1] = data;
    if (par_en) begin
      // even parity makes the count of ones over data and parity even
      bits[9] = par_odd ? ($countones(data) % 2 == 0) : ($countones(data) % 2 == 1);
    end
    return bits;
  endfunction

  function automatic logic level_of(input watch_e sel);
    logic v;
    case (sel)
      WatchTxAck:   v = tx_ack;
      WatchRdAck:   v = rd_ack;
      WatchRxAvail: v = rx_avail;
      default:      v = tx_idle;
    endcase
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wait_level(input watch_e sel, input logic level);
    int n;
    n = 0;
    while (level_of(sel) != level && n < Timeout) begin
      @(posedge clk_i);
      n++;
    end
    if (level_of(sel) != level) begin
      $display("timeout at %0d ns: %s never reached %0b", $time, sel.name(), level);
      err_cnt++;
    end
  endtask

  ////////////////////
  // host side
  ////////////////////

  task automatic raise_write(input byte_t data, input logic expected);
    if (expected) begin
      exp_q.push_back(data);
    end
    sent_q.push_back(data);
    tx_req  <= 1'b1;
    tx_data <= data;
  endtask

  task automatic write_byte(input byte_t data, input logic expected);
    raise_write(data, expected);
    wait_level(WatchTxAck, 1'b1);
    tx_req <= 1'b0;
    wait_level(WatchTxAck, 1'b0);
  endtask

  task automatic read_byte();
    wait_level(WatchRxAvail, 1'b1);
    rd_req <= 1'b1;
    wait_level(WatchRdAck, 1'b1);
    rd_req <= 1'b0;
    wait_level(WatchRdAck, 1'b0);
  endtask

  task automatic run_loopback(input logic par_en, input logic par_odd, input int count);
    byte_t data;
    @(posedge clk_i);
    cfg.parity_en  <= par_en;
    cfg.parity_odd <= par_odd;
    for (int i = 0; i < count; i++) begin
      data = byte_t'($urandom());
      write_byte(data, 1'b1);
    end
    for (int i = 0; i < count; i++) begin
      read_byte();
    end
    wait_level(WatchTxIdle, 1'b1);
  endtask

  // one bit per BitClks clocks straight onto rx_i
  task automatic send_raw_frame(input logic [10:0] bits, input int nbits);
    inject_en <= 1'b1;
    for (int i = 0; i < nbits; i++) begin
      inject_bit <= bits[i];
      repeat (BitClks) @(posedge clk_i);
    end
    inject_bit <= 1'b1;
  endtask

  ////////////////////
  // checkers
  ////////////////////

  always @(posedge clk_i) begin
    byte_t exp_byte;
    rd_ack_q <= rd_ack;
    if (rd_ack && !rd_ack_q) begin
      if (exp_q.size() == 0) begin
        $display("read of %h at %0d ns with no byte expected", rd_data, $time);
        err_cnt++;
      end else begin
        exp_byte = exp_q.pop_front();
        compare_value("rd_data_o", rd_data, exp_byte);
      end
    end
  end

  // tx_o sampled at mid-bit against the reference frame
  initial begin
    logic [10:0] line_bits;
    int          nbits;
    forever begin
      @(posedge clk_i);
      if (rst_ni && !tx_line) begin
        nbits     = cfg.parity_en ? 11 : 10;
        line_bits = '1;
        if (sent_q.size() == 0) begin
          $display("start bit on tx_o at %0d ns with no byte written", $time);
          err_cnt++;
        end else begin
          line_bits = frame_bits(sent_q.pop_front(), cfg.parity_en, cfg.parity_odd);
        end
        repeat (BitClks / 2 - 1) @(posedge clk_i);
        for (int i = 0; i < nbits; i++) begin
          compare_value("tx_o", tx_line, line_bits[i]);
          if (i < nbits - 1) begin
            repeat (BitClks) @(posedge clk_i);
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (rx_err.frame) begin
      frame_cnt++;
    end
    if (rx_err.parity) begin
      parity_cnt++;
    end
    if (rx_err.overflow) begin
      ovf_cnt++;
    end
  end

  initial begin
    byte_t       data;
    logic [10:0] bits;
    int          start;
    int          n;
    void'($urandom(32'hc26e));
    rst_ni     = 1'b0;
    cfg        = '{tx_en: 1'b1, rx_en: 1'b1, parity_en: 1'b0, parity_odd: 1'b0, nco: NcoInc};
    tx_req     = 1'b0;
    tx_data    = '0;
    rd_req     = 1'b0;
    inject_en  = 1'b0;
    inject_bit = 1'b1;
    rd_ack_q   = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // idle outputs straight after reset
    compare_value("tx_o", tx_line, 8'h01);
    compare_value("tx_idle_o", tx_idle, 8'h01);
    compare_value("tx_ack_o", tx_ack, 8'h00);
    compare_value("rd_ack_o", rd_ack, 8'h00);
    compare_value("rx_avail_o", rx_avail, 8'h00);
    compare_value("rx_err_o", rx_err, 8'h00);

    run_loopback(1'b0, 1'b0, 4);
    run_loopback(1'b1, 1'b0, 4);
    run_loopback(1'b1, 1'b1, 4);

    // even parity frame with its parity bit flipped
    @(posedge clk_i);
    cfg.parity_odd <= 1'b0;
    bits    = frame_bits(byte_t'($urandom()), 1'b1, 1'b0);
    bits[9] = ~bits[9];
    send_raw_frame(bits, 11);
    compare_value("parity pulses", 8'(parity_cnt), 8'd1);
    compare_value("rx_avail_o", rx_avail, 8'h00);

    // stop bit forced low with parity off
    cfg.parity_en <= 1'b0;
    bits    = frame_bits(byte_t'($urandom()), 1'b0, 1'b0);
    bits[9] = 1'b0;
    send_raw_frame(bits, 10);
    compare_value("frame pulses", 8'(frame_cnt), 8'd1);
    compare_value("rx_avail_o", rx_avail, 8'h00);
    inject_en <= 1'b0;

    // back-pressure with the transmitter held off
    @(posedge clk_i);
    cfg.tx_en <= 1'b0;
    for (int i = 0; i < TxDepth; i++) begin
      write_byte(byte_t'($urandom()), 1'b1);
    end
    raise_write(byte_t'($urandom()), 1'b1);
    check_cnt++;
    repeat (BitClks) begin
      @(posedge clk_i);
      if (tx_ack) begin
        $display("tx_ack_o rose at %0d ns while the TX FIFO was full", $time);
        err_cnt++;
      end
    end
    cfg.tx_en <= 1'b1;
    wait_level(WatchTxAck, 1'b1);
    compare_value("tx_idle_o", tx_idle, 8'h00);
    tx_req <= 1'b0;
    wait_level(WatchTxAck, 1'b0);
    for (int i = 0; i <= TxDepth; i++) begin
      read_byte();
    end
    wait_level(WatchTxIdle, 1'b1);

    // one byte more than the RX FIFO holds so the last one is dropped
    start = ovf_cnt;
    for (int i = 0; i <= RxDepth; i++) begin
      data = byte_t'($urandom());
      write_byte(data, i < RxDepth);
    end
    n = 0;
    while (ovf_cnt == start && n < Timeout) begin
      @(posedge clk_i);
      n++;
    end
    compare_value("overflow pulses", 8'(ovf_cnt - start), 8'd1);
    for (int i = 0; i < RxDepth; i++) begin
      read_byte();
    end
    compare_value("rx_avail_o", rx_avail, 8'h00);

    compare_value("frame pulses", 8'(frame_cnt), 8'd1);
    compare_value("parity pulses", 8'(parity_cnt), 8'd1);
    compare_value("bytes still expected", 8'(exp_q.size()), 8'd0);
    compare_value("bytes never sent on tx_o", 8'(sent_q.size()), 8'd0);

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- project.f
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_req_ack_port.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
tests/uart_props.sv
tests/uart_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f project.f

out="$(./obj_dir/Vuart_tb)"
printf '%s\n' "$out"

# the run passes only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx '=== PASS ==='
